// File: verilog/acq_pkg.sv
// acquisition package with shared widths, the register map and the sequencer states.
package acq_pkg;

  ////////////////////
  // widths.
  localparam int COUNT_W = 24;
  localparam int SAMPLE_W = 24;
  localparam int SEQ_W = 8;
  localparam int ADDR_W = 2;

  // cycle counts for the precharge pause and the aperture.
  typedef logic [COUNT_W-1:0] count_t;
  // a conversion result, the number of ones seen in the aperture.
  typedef logic [SAMPLE_W-1:0] sample_t;
  // running sample number, wraps at 256.
  typedef logic [SEQ_W-1:0] seq_t;
  typedef logic [ADDR_W-1:0] reg_addr_t;
  typedef logic [COUNT_W-1:0] reg_data_t;

  ////////////////////
  // register map. bit 0 of control is arm.
  localparam reg_addr_t REG_PRECHARGE = 2'd0;
  localparam reg_addr_t REG_APERTURE = 2'd1;
  localparam reg_addr_t REG_CONTROL = 2'd2;

  // sequencer states.
  typedef enum logic [2:0] {
    ST_START,
    ST_PRECHARGE_LOAD,
    ST_PRECHARGE_WAIT,
    ST_TRIGGER,
    ST_WAIT_ADC,
    ST_PARK
  } seq_state_t;

endpackage

// File: verilog/acq_regs.sv
// configuration register block, write-only, holding precharge, aperture and arm.
`timescale 1ns/100ps

module acq_regs #(
  parameter acq_pkg::count_t RESET_PRECHARGE = 24'd16,
  parameter acq_pkg::count_t RESET_APERTURE = 24'd64
) (
  input  logic               clk,
  input  logic               rst,

  // write port.
  input  logic               cfg_valid,
  input  acq_pkg::reg_addr_t cfg_addr,
  input  acq_pkg::reg_data_t cfg_data,
  output logic               cfg_ready,

  // configuration fields.
  output acq_pkg::count_t    precharge_count,
  output acq_pkg::count_t    aperture_count,
  output logic               arm
);

  logic cfg_write;

  // a write is taken on a valid/ready handshake.
  assign cfg_write = cfg_valid && cfg_ready;

  ////////////////////
  // register file.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      // ready comes up on the first cycle out of reset.
      cfg_ready <= 1'b0;
      precharge_count <= RESET_PRECHARGE;
      aperture_count <= RESET_APERTURE;
      // armed at reset, so sampling starts on its own.
      arm <= 1'b1;
    end
    else
    begin
      // always able to take a write.
      cfg_ready <= 1'b1;
      if (cfg_write)
      begin
        case (cfg_addr)
          acq_pkg::REG_PRECHARGE:
            precharge_count <= cfg_data;
          acq_pkg::REG_APERTURE:
            aperture_count <= cfg_data;
          acq_pkg::REG_CONTROL:
            arm <= cfg_data[0];
          default:
            // unused address, accepted and dropped.
            ;
        endcase
      end
    end
  end

  ////////////////////
  // once the first cycle after reset is past, the port never stalls a write.
  a_ready_high: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> cfg_ready);

endmodule

// File: verilog/acq_sequencer.sv
// sample sequencer, precharge pause then converter trigger then wait, with arm edge control.
`timescale 1ns/100ps

module acq_sequencer (
  input  logic            clk,
  input  logic            rst,

  // configuration.
  input  logic            arm,
  input  acq_pkg::count_t precharge_count,

  // converter handshake.
  input  logic            measure_valid,
  output logic            measure_trig,

  // status.
  output logic            led,
  output logic [1:0]      monitor
);

  acq_pkg::seq_state_t state;
  acq_pkg::count_t     count_down;

  // arm history, {older, newer}.
  logic [1:0] arm_hist;
  logic       arm_rise;
  logic       arm_fall;

  assign arm_rise = (arm_hist == 2'b01);
  assign arm_fall = (arm_hist == 2'b10);

  // scope pins, trigger on bit 0 and converter valid on bit 1.
  assign monitor = {measure_valid, measure_trig};

  ////////////////////
  // state machine.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= acq_pkg::ST_START;
      count_down <= '0;
      measure_trig <= 1'b0;
      led <= 1'b0;
      // arm resets high, so no edge is seen on leaving reset.
      arm_hist <= 2'b11;
    end
    else
    begin
      arm_hist <= {arm_hist[0], arm};

      case (state)
        acq_pkg::ST_START:
          // one spare cycle, handy as a marker on the monitor.
          state <= acq_pkg::ST_PRECHARGE_LOAD;

        acq_pkg::ST_PRECHARGE_LOAD:
        begin
          count_down <= precharge_count;
          // one toggle per sample, so the rate shows on the led.
          led <= ~led;
          state <= acq_pkg::ST_PRECHARGE_WAIT;
        end

        acq_pkg::ST_PRECHARGE_WAIT:
        begin
          // precharge_count cycles in this state.
          if (count_down > acq_pkg::count_t'(1))
            count_down <= count_down - 1'b1;
          else
            state <= acq_pkg::ST_TRIGGER;
        end

        acq_pkg::ST_TRIGGER:
        begin
          // hold the trigger until the converter drops valid.
          measure_trig <= 1'b1;
          if (!measure_valid)
          begin
            measure_trig <= 1'b0;
            state <= acq_pkg::ST_WAIT_ADC;
          end
        end

        acq_pkg::ST_WAIT_ADC:
          // converter done, start the next precharge.
          if (measure_valid)
            state <= acq_pkg::ST_PRECHARGE_LOAD;

        acq_pkg::ST_PARK:
          // parked until a rising arm edge.
          ;

        default:
          state <= acq_pkg::ST_START;
      endcase

      // arm edges take priority over the case above.
      if (arm_rise)
      begin
        state <= acq_pkg::ST_PRECHARGE_LOAD;
        measure_trig <= 1'b0;
      end
      else if (arm_fall)
      begin
        // a conversion already started still runs to the end in the converter.
        state <= acq_pkg::ST_PARK;
        measure_trig <= 1'b0;
      end
    end
  end

  ////////////////////
  // the trigger only lives in the trigger state.
  a_trig_in_trigger: assert property (@(posedge clk) disable iff (rst)
    measure_trig |-> state == acq_pkg::ST_TRIGGER);

  // park holds while arm is low now and in the history.
  a_park_holds: assert property (@(posedge clk) disable iff (rst)
    (state == acq_pkg::ST_PARK && !arm && !arm_hist[0]) |=> state == acq_pkg::ST_PARK);

endmodule

// File: verilog/adc_counter.sv
// counting converter, totals the ones of the modulator bitstream over the aperture.
`timescale 1ns/100ps

module adc_counter (
  input  logic             clk,
  input  logic             rst,

  // trigger handshake.
  input  logic             measure_trig,
  output logic             measure_valid,

  // modulator bitstream.
  input  logic             bitstream,

  // configuration.
  input  acq_pkg::count_t  aperture_count,

  // result path.
  output acq_pkg::sample_t result,
  output logic             result_strobe
);

  typedef enum logic {
    ADC_IDLE,
    ADC_COUNT
  } adc_state_t;

  adc_state_t       state;
  // cycles left in the aperture, including the current one.
  acq_pkg::count_t  remaining;
  acq_pkg::sample_t accum;

  ////////////////////
  // control.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= ADC_IDLE;
      measure_valid <= 1'b1;
      result_strobe <= 1'b0;
    end
    else
    begin
      result_strobe <= 1'b0;
      case (state)
        ADC_IDLE:
          if (measure_trig)
          begin
            // busy from the next cycle.
            measure_valid <= 1'b0;
            state <= ADC_COUNT;
          end

        ADC_COUNT:
          // triggers are ignored here.
          if (remaining <= acq_pkg::count_t'(1))
          begin
            measure_valid <= 1'b1;
            result_strobe <= 1'b1;
            state <= ADC_IDLE;
          end

        default:
          state <= ADC_IDLE;
      endcase
    end
  end

  ////////////////////
  // datapath.
  always_ff @(posedge clk)
  begin
    if (state == ADC_IDLE)
    begin
      // latch the aperture at the start, later writes wait for the next one.
      remaining <= aperture_count;
      accum <= '0;
    end
    else
    begin
      remaining <= remaining - 1'b1;
      accum <= accum + acq_pkg::sample_t'(bitstream);
      // last aperture cycle, include this bit in the total.
      if (remaining <= acq_pkg::count_t'(1))
        result <= accum + acq_pkg::sample_t'(bitstream);
    end
  end

  ////////////////////
  // a result only comes with the return of valid.
  a_strobe_on_rise: assert property (@(posedge clk) disable iff (rst)
    result_strobe |-> measure_valid && !$past(measure_valid));

endmodule

// File: verilog/sample_out.sv
// sample output stage, one holding register with valid/ready, sequence stamp and overrun count.
`timescale 1ns/100ps

module sample_out (
  input  logic             clk,
  input  logic             rst,

  // from the converter.
  input  acq_pkg::sample_t result,
  input  logic             result_strobe,

  // sample port.
  input  logic             sample_ready,
  output logic             sample_valid,
  output acq_pkg::sample_t sample_data,
  output acq_pkg::seq_t    sample_seq,

  // results dropped under back-pressure.
  output logic [7:0]       overrun_count
);

  acq_pkg::seq_t seq_next;
  logic          transfer;
  logic          load;

  assign transfer = sample_valid && sample_ready;
  // register is free when empty, or when the held sample leaves this cycle.
  assign load = result_strobe && (!sample_valid || transfer);

  ////////////////////
  // control.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      sample_valid <= 1'b0;
      seq_next <= '0;
      overrun_count <= '0;
    end
    else
    begin
      if (load)
        sample_valid <= 1'b1;
      else if (transfer)
        sample_valid <= 1'b0;

      // every result takes a number, kept or not.
      if (result_strobe)
      begin
        seq_next <= seq_next + 1'b1;
        if (!load)
          overrun_count <= overrun_count + 1'b1;
      end
    end
  end

  // holding register.
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      sample_data <= result;
      sample_seq <= seq_next;
    end
  end

  ////////////////////
  // a stalled sample stays put.
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    (sample_valid && !sample_ready) |=> $stable(sample_data) && $stable(sample_seq));

endmodule

// File: verilog/acq_top.sv
// acquisition top, joins the register block, sequencer, converter and output stage.
`timescale 1ns/100ps

module acq_top #(
  parameter acq_pkg::count_t RESET_PRECHARGE = 24'd16,
  parameter acq_pkg::count_t RESET_APERTURE = 24'd64
) (
  input  logic               clk,
  input  logic               rst,

  // register write port.
  input  logic               cfg_valid,
  input  acq_pkg::reg_addr_t cfg_addr,
  input  acq_pkg::reg_data_t cfg_data,
  output logic               cfg_ready,

  // modulator bitstream.
  input  logic               bitstream,

  // sample port.
  output logic               sample_valid,
  input  logic               sample_ready,
  output acq_pkg::sample_t   sample_data,
  output acq_pkg::seq_t      sample_seq,
  output logic [7:0]         overrun_count,

  // status.
  output logic               led,
  output logic [1:0]         monitor
);

  acq_pkg::count_t  precharge_count;
  acq_pkg::count_t  aperture_count;
  logic             arm;
  logic             measure_trig;
  logic             measure_valid;
  acq_pkg::sample_t result;
  logic             result_strobe;

  ////////////////////
  acq_regs #(
    .RESET_PRECHARGE (RESET_PRECHARGE),
    .RESET_APERTURE  (RESET_APERTURE)
  ) u_regs (
    .clk             (clk),
    .rst             (rst),
    .cfg_valid       (cfg_valid),
    .cfg_addr        (cfg_addr),
    .cfg_data        (cfg_data),
    .cfg_ready       (cfg_ready),
    .precharge_count (precharge_count),
    .aperture_count  (aperture_count),
    .arm             (arm)
  );

  acq_sequencer u_sequencer (
    .clk             (clk),
    .rst             (rst),
    .arm             (arm),
    .precharge_count (precharge_count),
    .measure_valid   (measure_valid),
    .measure_trig    (measure_trig),
    .led             (led),
    .monitor         (monitor)
  );

  adc_counter u_adc (
    .clk            (clk),
    .rst            (rst),
    .measure_trig   (measure_trig),
    .measure_valid  (measure_valid),
    .bitstream      (bitstream),
    .aperture_count (aperture_count),
    .result         (result),
    .result_strobe  (result_strobe)
  );

  sample_out u_out (
    .clk           (clk),
    .rst           (rst),
    .result        (result),
    .result_strobe (result_strobe),
    .sample_ready  (sample_ready),
    .sample_valid  (sample_valid),
    .sample_data   (sample_data),
    .sample_seq    (sample_seq),
    .overrun_count (overrun_count)
  );

endmodule

// File: tests/acq_checker.sv
// acquisition checker that watches the DUT ports and compares them against the expected counts.
`timescale 1ns/100ps

module acq_checker #(
  parameter int PERIOD = 8
) (
  input  logic             clk,
  input  logic             rst,
  // dut ports watched.
  input  logic             sample_valid,
  input  logic             sample_ready,
  input  acq_pkg::sample_t sample_data,
  input  acq_pkg::seq_t    sample_seq,
  input  logic [7:0]       overrun_count,
  input  logic             led,
  input  logic [1:0]       monitor,
  // test control from the testbench.
  input  logic [7:0]       pattern,
  input  acq_pkg::count_t  aperture,
  input  logic             check_data,
  input  logic             check_interval,
  input  int               interval_exp,
  input  logic             check_led,
  input  logic             parked,
  input  logic [2:0]       test_id,
  input  logic             test_done,
  input  logic             all_done,
  output int               error_count
);

  int cycle = 0;
  int checks = 0;
  int samples = 0;
  int test_errors = 0;
  int test_samples = 0;
  int last_rise = 0;
  int led_changes = 0;
  int park_samples = 0;
  int busy_len = 0;
  logic prev_valid, prev_transfer, prev_stall, prev_led, prev_mvalid;
  logic have_seq, have_int, have_led;
  logic transfer, new_sample, rise;
  acq_pkg::sample_t held_data;
  acq_pkg::seq_t held_seq, last_seq, exp_seq;
  logic [7:0] last_ov;

  initial error_count = 0;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: return "extremes";
      3'd1: return "density";
      3'd2: return "interval";
      3'd3: return "backpressure";
      3'd4: return "park_rearm";
      default: return "led";
    endcase
  endfunction

  // expected count is the aperture times the ones per period over the period.
  function automatic acq_pkg::sample_t expected_count(input logic [7:0] pat,
                                                      input acq_pkg::count_t ap);
    int ones;
    ones = 0;
    for (int i = 0; i < PERIOD; i++)
      if (pat[i])
        ones++;
    return acq_pkg::sample_t'((int'(ap) * ones) / PERIOD);
  endfunction

  task automatic report_value(input int exp, input int act);
    error_count++;
    test_errors++;
    $display("[ERROR] %s: expected %0d, actual %0d", test_name(test_id), exp, act);
  endtask

  task automatic report_plain(input string msg);
    error_count++;
    test_errors++;
    $display("%s: %s", test_name(test_id), msg);
  endtask

  ////////////////////
  always @(posedge clk)
  begin
    cycle++;
    if (rst)
    begin
      prev_valid = 1'b0;
      prev_transfer = 1'b0;
      prev_stall = 1'b0;
      prev_led = led;
      prev_mvalid = 1'b1;
      busy_len = 0;
      have_seq = 1'b0;
      have_int = 1'b0;
      have_led = 1'b0;
    end
    else
    begin
      transfer = sample_valid && sample_ready;
      // a new sample shows after an empty cycle or right behind a transfer.
      new_sample = sample_valid && (!prev_valid || prev_transfer);
      rise = sample_valid && !prev_valid;

      // stalled sample must not move.
      if (prev_stall)
      begin
        checks++;
        if (sample_data != held_data)
          report_value(int'(held_data), int'(sample_data));
        if (sample_seq != held_seq)
          report_value(int'(held_seq), int'(sample_seq));
      end

      if (transfer)
      begin
        samples++;
        test_samples++;
        if (check_data)
        begin
          checks++;
          if (sample_data != expected_count(pattern, aperture))
            report_value(int'(expected_count(pattern, aperture)), int'(sample_data));
        end
      end

      // sequence step is one plus the drops in between, mod 256.
      if (new_sample)
      begin
        if (have_seq)
        begin
          checks++;
          exp_seq = last_seq + 8'd1 + (overrun_count - last_ov);
          if (sample_seq != exp_seq)
            report_value(int'(exp_seq), int'(sample_seq));
        end
        have_seq = 1'b1;
        last_seq = sample_seq;
        last_ov = overrun_count;
      end

      // one led toggle between consecutive samples.
      if (led != prev_led)
        led_changes++;
      if (rise)
      begin
        if (check_led && have_led)
        begin
          checks++;
          if (led_changes != 1)
            report_value(1, led_changes);
        end
        have_led = check_led;
        led_changes = 0;
      end
      if (!check_led)
        have_led = 1'b0;

      // distance between valid rises.
      if (rise)
      begin
        if (check_interval && have_int)
        begin
          checks++;
          if (cycle - last_rise != interval_exp)
            report_value(interval_exp, cycle - last_rise);
        end
        last_rise = cycle;
        have_int = check_interval;
      end
      if (!check_interval)
        have_int = 1'b0;

      // while parked only the conversion in flight may still come out.
      if (parked)
      begin
        if (new_sample)
        begin
          park_samples++;
          checks++;
          if (park_samples > 1)
            report_plain("a sample appeared while the sequencer was parked");
        end
      end
      else
        park_samples = 0;

      // converter busy time on the monitor pins, one aperture per conversion.
      if (!monitor[1])
      begin
        busy_len++;
        // the trigger drops once the converter is seen busy.
        if (monitor[0] && busy_len > 1)
          report_plain("the trigger stayed high while the converter was busy");
      end
      else if (!prev_mvalid)
      begin
        checks++;
        if (busy_len != int'(aperture))
          report_value(int'(aperture), busy_len);
        busy_len = 0;
      end

      prev_valid = sample_valid;
      prev_transfer = transfer;
      prev_stall = sample_valid && !sample_ready;
      prev_led = led;
      prev_mvalid = monitor[1];
      held_data = sample_data;
      held_seq = sample_seq;

      if (test_done)
      begin
        $display("test %s done: %0d samples, %0d errors", test_name(test_id),
                 test_samples, test_errors);
        test_samples = 0;
        test_errors = 0;
      end
      if (all_done)
        $display("summary: %0d samples, %0d checks, %0d errors", samples, checks,
                 error_count);
    end
  end

endmodule

// File: tests/tb_acq_top.sv
// acquisition testbench that drives registers, bitstream and ready, and runs the test list.
`timescale 1ns/100ps

module tb_acq_top;

  localparam acq_pkg::count_t PRECHARGE = 24'd16;
  localparam acq_pkg::count_t APERTURE = 24'd64;
  localparam int PERIOD = 8;
  localparam int BASE = 16 + 64 + 4;
  // cycle budget from the samples per test times the sample interval, plus margin.
  localparam int LIMIT = 12 * BASE + 20 * BASE + 6 * 78 + 6 * 98 + 4 * BASE
                       + 12 * (BASE + 260) + 9 * BASE + 6 * BASE + 2000;

  logic clk, rst, cfg_valid, cfg_ready, bitstream;
  acq_pkg::reg_addr_t cfg_addr;
  acq_pkg::reg_data_t cfg_data;
  logic sample_valid, sample_ready, led;
  acq_pkg::sample_t sample_data;
  acq_pkg::seq_t sample_seq;
  logic [7:0] overrun_count;
  logic [1:0] monitor;

  logic [7:0] pattern;
  logic check_data, check_interval, check_led, parked, test_done, all_done, gaps_done;
  logic [2:0] test_id;
  int interval_exp;
  int error_count;
  int cycles = 0;
  logic [15:0] lfsr = 16'd60;
  logic [2:0] phase = 3'd0;

  acq_top #(
    .RESET_PRECHARGE (PRECHARGE),
    .RESET_APERTURE  (APERTURE)
  ) uut (
    .clk (clk), .rst (rst),
    .cfg_valid (cfg_valid), .cfg_addr (cfg_addr), .cfg_data (cfg_data),
    .cfg_ready (cfg_ready), .bitstream (bitstream),
    .sample_valid (sample_valid), .sample_ready (sample_ready),
    .sample_data (sample_data), .sample_seq (sample_seq),
    .overrun_count (overrun_count), .led (led), .monitor (monitor)
  );

  acq_checker #(.PERIOD (PERIOD)) chk (
    .clk (clk), .rst (rst),
    .sample_valid (sample_valid), .sample_ready (sample_ready),
    .sample_data (sample_data), .sample_seq (sample_seq),
    .overrun_count (overrun_count), .led (led), .monitor (monitor),
    .pattern (pattern), .aperture (APERTURE), .check_data (check_data),
    .check_interval (check_interval), .interval_exp (interval_exp),
    .check_led (check_led), .parked (parked), .test_id (test_id),
    .test_done (test_done), .all_done (all_done), .error_count (error_count)
  );

  ////////////////////
  always #10 clk = ~clk;

  // periodic modulator bitstream.
  always @(posedge clk)
  begin
    #2;
    bitstream = pattern[phase];
    phase = phase + 3'd1;
  end

  // watchdog.
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("timeout: the tests did not finish within %0d cycles", LIMIT);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // fibonacci lfsr with taps 16 14 13 11.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = 8'd0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic write_reg(input acq_pkg::reg_addr_t addr, input acq_pkg::reg_data_t data);
    @(posedge clk);
    #2;
    cfg_valid = 1'b1;
    cfg_addr = addr;
    cfg_data = data;
    do
      @(posedge clk);
    while (!cfg_ready);
    #2;
    cfg_valid = 1'b0;
  endtask

  task automatic wait_transfers(input int n);
    int seen;
    seen = 0;
    while (seen < n)
    begin
      @(posedge clk);
      if (sample_valid && sample_ready)
        seen++;
    end
  endtask

  // change the pattern and skip the samples that straddle the change.
  task automatic set_pattern(input logic [7:0] pat);
    @(posedge clk);
    #2;
    check_data = 1'b0;
    pattern = pat;
    wait_transfers(2);
    #2;
    check_data = 1'b1;
  endtask

  // report the finished test, then move on to the next one.
  task automatic end_test(input logic [2:0] id);
    @(posedge clk);
    #2;
    test_done = 1'b1;
    @(posedge clk);
    #2;
    test_done = 1'b0;
    test_id = id + 3'd1;
  endtask

  task automatic interval_run(input acq_pkg::reg_data_t pre);
    write_reg(acq_pkg::REG_PRECHARGE, pre);
    wait_transfers(2);
    #2;
    interval_exp = int'(pre) + int'(APERTURE) + 4;
    check_interval = 1'b1;
    wait_transfers(4);
    #2;
    check_interval = 1'b0;
  endtask

  ////////////////////
  initial
  begin
    logic [7:0] bits;
    clk = 1'b0;
    rst = 1'b1;
    cfg_valid = 1'b0;
    cfg_addr = '0;
    cfg_data = '0;
    bitstream = 1'b0;
    sample_ready = 1'b1;
    pattern = 8'h00;
    check_data = 1'b0;
    check_interval = 1'b0;
    check_led = 1'b0;
    parked = 1'b0;
    test_done = 1'b0;
    all_done = 1'b0;
    gaps_done = 1'b0;
    test_id = 3'd0;
    interval_exp = 0;
    repeat (8) @(posedge clk);
    #2;
    rst = 1'b0;

    // all zeros, then all ones.
    set_pattern(8'h00);
    wait_transfers(4);
    set_pattern(8'hff);
    wait_transfers(4);
    end_test(3'd0);

    for (int i = 0; i < 4; i++)
    begin
      take_bits(8, bits);
      set_pattern(bits);
      wait_transfers(3);
    end
    end_test(3'd1);

    interval_run(24'd10);
    interval_run(24'd30);
    write_reg(acq_pkg::REG_PRECHARGE, PRECHARGE);
    wait_transfers(2);
    end_test(3'd2);

    // random ready gaps long enough to force drops.
    fork
      begin
        wait_transfers(12);
        gaps_done = 1'b1;
      end
      begin
        while (!gaps_done)
        begin
          take_bits(6, bits);
          @(posedge clk);
          #2;
          sample_ready = 1'b0;
          repeat (int'(bits) * 4) @(posedge clk);
          #2;
          sample_ready = 1'b1;
          take_bits(2, bits);
          repeat (int'(bits) + 1) @(posedge clk);
        end
      end
    join
    end_test(3'd3);

    write_reg(acq_pkg::REG_CONTROL, 24'd0);
    #2;
    parked = 1'b1;
    // one interval for the conversion in flight, three with nothing.
    repeat (4 * BASE) @(posedge clk);
    #2;
    parked = 1'b0;
    write_reg(acq_pkg::REG_CONTROL, 24'd1);
    wait_transfers(5);
    end_test(3'd4);

    #2;
    check_led = 1'b1;
    wait_transfers(6);
    #2;
    check_led = 1'b0;
    end_test(3'd5);

    @(posedge clk);
    #2;
    all_done = 1'b1;
    @(posedge clk);
    #2;
    all_done = 1'b0;
    if (error_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: acq_top.f
verilog/acq_pkg.sv
verilog/acq_regs.sv
verilog/acq_sequencer.sv
verilog/adc_counter.sv
verilog/sample_out.sv
verilog/acq_top.sv
tests/acq_checker.sv
tests/tb_acq_top.sv

// File: Makefile
# Verilator build and run for the acquisition path testbench.

VERILATOR ?= verilator
TOP       ?= tb_acq_top
FILELIST  ?= acq_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run into the log, then pass only if the log holds the pass line.
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
